// File: compile.f
+incdir+verilog
verilog/fetchPkg.sv
verilog/icache.sv
verilog/icacheArbiter.sv
verilog/fetchBuffer.sv
verilog/fetchTop.sv
tests/fetch_assert.sv
tests/fetchTb.sv

// File: irom.hex
// One 32-bit instruction word per line, word 0 first (addi rd, x0, index)
00000093
00100113
00200193
00300213
00400293
00500313
00600393
00700413
00800493
00900513
00a00593
00b00613
00c00693
00d00713
00e00793
00f00813
01000893
01100913
01200993
01300a13
01400a93
01500b13
01600b93
01700c13
01800c93
01900d13
01a00d93
01b00e13
01c00e93
01d00f13
01e00f93
01f00093
02000113
02100193
02200213
02300293
02400313
02500393
02600413
02700493
02800513
02900593
02a00613
02b00693
02c00713
02d00793
02e00813
02f00893
03000913
03100993
03200a13
03300a93
03400b13
03500b93
03600c13
03700c93
03800d13
03900d93
03a00e13
03b00e93
03c00f13
03d00f93
03e00093
03f00113
04000193
04100213
04200293
04300313
04400393
04500413
04600493
04700513
04800593
04900613
04a00693
04b00713
04c00793
04d00813
04e00893
04f00913
05000993
05100a13
05200a93
05300b13
05400b93
05500c13
05600c93
05700d13
05800d93
05900e13
05a00e93
05b00f13
05c00f93
05d00093
05e00113
05f00193
06000213
06100293
06200313
06300393
06400413
06500493
06600513
06700593
06800613
06900693
06a00713
06b00793
06c00813
06d00893
06e00913
06f00993
07000a13
07100a93
07200b13
07300b93
07400c13
07500c93
07600d13
07700d93
07800e13
07900e93
07a00f13
07b00f93
07c00093
07d00113
07e00193
07f00213

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps -f compile.f \
    --top-module fetchTb -o fetchSim

./obj_dir/fetchSim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi

// File: tests/fetchTb.sv
`include "icache_defines.svh"

module fetchTb;

    timeunit 1ns;
    timeprecision 100ps;

    import fetchPkg::*;

    localparam int RANDOM_RUNS = 200;
    // Directed lines plus the longest possible random runs
    localparam int MAX_LINES = 5 + 3 + 12 + RANDOM_RUNS * 15;
    localparam int TIMEOUT_CYCLES = MAX_LINES * 40 + 500;

    logic        clk;
    logic        reset;
    logic        start0;
    logic [31:0] startPc0;
    logic [3:0]  lineCount0;
    logic        busy0;
    logic        lineValid0;
    logic [31:0] linePc0;
    tLine        lineData0;
    logic        start1;
    logic [31:0] startPc1;
    logic [3:0]  lineCount1;
    logic        busy1;
    logic        lineValid1;
    logic [31:0] linePc1;
    tLine        lineData1;

    // ROM image and the line addresses still owed to each port
    tWord        model [`ICACHE_WORDS];
    logic [31:0] expPc0 [$];
    logic [31:0] expPc1 [$];
    integer      seed;
    string       testName;

    fetchTop i_dut (
        .clk        (clk),
        .reset      (reset),
        .start0     (start0),
        .startPc0   (startPc0),
        .lineCount0 (lineCount0),
        .busy0      (busy0),
        .lineValid0 (lineValid0),
        .linePc0    (linePc0),
        .lineData0  (lineData0),
        .start1     (start1),
        .startPc1   (startPc1),
        .lineCount1 (lineCount1),
        .busy1      (busy1),
        .lineValid1 (lineValid1),
        .linePc1    (linePc1),
        .lineData1  (lineData1)
    );

    always #5 clk = ~clk;

    task automatic checkValue(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run aborted");
    endtask

    // Four words from the word index of pc, wrapping at the end of the ROM
    function automatic tLine modelLine(input logic [31:0] pc);
        tLine       line;
        logic [6:0] idx;
        idx = pc[8:2];
        for (int w = 0; w < `LINE_WORDS; w++) begin
            line[w] = model[idx + 7'(w)];
        end
        return line;
    endfunction

    task automatic issueStart(input int port, input logic [31:0] pc, input logic [3:0] count);
        if (port == 0) begin
            start0     = 1'b1;
            startPc0   = pc;
            lineCount0 = count;
        end else begin
            start1     = 1'b1;
            startPc1   = pc;
            lineCount1 = count;
        end
        for (int i = 0; i < int'(count); i++) begin
            if (port == 0) begin
                expPc0.push_back(pc + 32'(16 * i));
            end else begin
                expPc1.push_back(pc + 32'(16 * i));
            end
        end
    endtask

    task automatic checkLine(input int port, input logic [31:0] pc, input tLine data);
        logic [31:0] expected;
        if ((port == 0 && expPc0.size() == 0) || (port == 1 && expPc1.size() == 0)) begin
            failRun($sformatf("Port %0d presented a line that no run asked for", port));
        end else begin
            if (port == 0) begin
                expected = expPc0.pop_front();
            end else begin
                expected = expPc1.pop_front();
            end
            checkValue($sformatf("%s port%0d linePc", testName, port), 128'(expected), 128'(pc));
            checkValue($sformatf("%s port%0d lineData", testName, port),
                       modelLine(expected), data);
        end
    endtask

    // Drop the start strobes one cycle after they were raised
    task automatic endStrobe();
        @(negedge clk);
        start0 = 1'b0;
        start1 = 1'b0;
    endtask

    // Both ports idle, then every promised line must have arrived
    task automatic waitDone();
        while (busy0 || busy1) begin
            @(negedge clk);
        end
        checkValue({testName, " lines missing port0"}, 128'(0), 128'(expPc0.size()));
        checkValue({testName, " lines missing port1"}, 128'(0), 128'(expPc1.size()));
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (!reset) begin
            if (lineValid0) begin
                checkLine(0, linePc0, lineData0);
            end
            if (lineValid1) begin
                checkLine(1, linePc1, lineData1);
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("The run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int runsIssued;
        seed       = 32'h42e7;
        clk        = 1'b0;
        reset      = 1'b1;
        start0     = 1'b0;
        startPc0   = 32'd0;
        lineCount0 = 4'd0;
        start1     = 1'b0;
        startPc1   = 32'd0;
        lineCount1 = 4'd0;
        testName   = "reset";
        $readmemh("irom.hex", model);
        repeat (8) @(negedge clk);
        reset = 1'b0;

        testName = "idle";
        repeat (10) begin
            @(negedge clk);
            checkValue({testName, " busy and lineValid"}, 128'(0),
                       128'({busy0, busy1, lineValid0, lineValid1}));
        end

        testName = "aligned";
        issueStart(0, 32'h0000_0040, 4'd5);
        endStrobe();
        waitDone();

        // Word 125 onward, so the first lines cross the end of the ROM
        testName = "wrap";
        issueStart(0, 32'h0000_01f6, 4'd3);
        endStrobe();
        waitDone();

        testName = "contention";
        issueStart(0, 32'h0000_0100, 4'd6);
        issueStart(1, 32'h0000_0120, 4'd6);
        endStrobe();
        waitDone();

        testName   = "random";
        runsIssued = 0;
        while (runsIssued < RANDOM_RUNS) begin
            @(negedge clk);
            start0 = 1'b0;
            start1 = 1'b0;
            for (int p = 0; p < 2; p++) begin
                if (runsIssued < RANDOM_RUNS && !(p == 0 ? busy0 : busy1)
                        && ($random(seed) & 3) == 0) begin
                    issueStart(p, $random(seed), 4'(($unsigned($random(seed)) % 15) + 1));
                    runsIssued++;
                end
            end
        end
        endStrobe();
        waitDone();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: tests/fetch_assert.sv
`include "icache_defines.svh"

module fetchAssert (
    input logic             clk,
    input logic             reset,
    input logic             reqValid0,
    input logic             reqValid1,
    input logic             pending0,
    input logic             pending1,
    input logic             icReqValid,
    input fetchPkg::tPortId icReqId,
    input logic             icRspValid
);

    timeunit 1ns;
    timeprecision 100ps;

    import fetchPkg::*;

    // Each grant drains a strobe taken one or two cycles earlier, and only once
    grantFromSlot0: assert property (@(posedge clk) disable iff (reset)
        (icReqValid && icReqId == tPortId'(0)) |->
            ($past(reqValid0) ||
             ($past(reqValid0, 2) && !$past(icReqValid && icReqId == tPortId'(0)))))
        else $error("Port 0 granted to the store with no pending request");

    grantFromSlot1: assert property (@(posedge clk) disable iff (reset)
        (icReqValid && icReqId == tPortId'(1)) |->
            ($past(reqValid1) ||
             ($past(reqValid1, 2) && !$past(icReqValid && icReqId == tPortId'(1)))))
        else $error("Port 1 granted to the store with no pending request");

    noOverwrite0: assert property (@(posedge clk) disable iff (reset)
        reqValid0 |-> !pending0)
        else $error("Port 0 request arrived while its slot was occupied");

    noOverwrite1: assert property (@(posedge clk) disable iff (reset)
        reqValid1 |-> !pending1)
        else $error("Port 1 request arrived while its slot was occupied");

    // Fixed store latency in both directions
    rspAfterReq: assert property (@(posedge clk) disable iff (reset)
        icReqValid |-> ##`ICACHE_LATENCY icRspValid)
        else $error("Store response missing after request");

    reqBeforeRsp: assert property (@(posedge clk) disable iff (reset)
        icRspValid |-> $past(icReqValid, `ICACHE_LATENCY))
        else $error("Store response without a matching request");

endmodule

bind icacheArbiter fetchAssert i_fetchAssert (
    .clk        (clk),
    .reset      (reset),
    .reqValid0  (reqValid0),
    .reqValid1  (reqValid1),
    .pending0   (pending0),
    .pending1   (pending1),
    .icReqValid (icReqValid),
    .icReqId    (icReqId),
    .icRspValid (icRspValid)
);

// File: verilog/fetchBuffer.sv
module fetchBuffer (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic [31:0]    startPc,
    input  logic [3:0]     lineCount,
    input  logic           rspValid,
    input  fetchPkg::tLine rspData,
    output logic           busy,
    output logic           lineValid,
    output logic [31:0]    linePc,
    output fetchPkg::tLine lineData,
    output logic           reqValid,
    output logic [31:0]    reqAddr
);

    import fetchPkg::*;

    tFetchState state;
    logic [31:0] pc;
    logic [3:0]  remaining;
    logic        accept;

    // Still busy in the cycle of the last lineValid
    assign busy = (state != IDLE) | lineValid;

    // A zero count would never terminate cleanly, so it is not a run
    assign accept = start & ~busy & (lineCount != 4'd0);

    // One request strobe per REQUEST visit
    assign reqValid = (state == REQUEST);
    assign reqAddr  = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            lineValid <= 1'b0;
        end else begin
            lineValid <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= REQUEST;
                    end
                end
                REQUEST: begin
                    state <= WAIT;
                end
                WAIT: begin
                    if (rspValid) begin
                        lineValid <= 1'b1;
                        if (remaining == 4'd1) begin
                            state <= IDLE;
                        end else begin
                            state <= REQUEST;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Run position and returned line
    always_ff @(posedge clk) begin
        if (accept) begin
            pc        <= startPc;
            remaining <= lineCount;
        end else if (state == WAIT && rspValid) begin
            pc        <= pc + 32'd16;
            remaining <= remaining - 4'd1;
        end
        if (state == WAIT && rspValid) begin
            linePc   <= pc;
            lineData <= rspData;
        end
    end

endmodule

// File: verilog/fetchPkg.sv
`include "icache_defines.svh"

package fetchPkg;

    // One instruction word
    typedef logic [31:0] tWord;

    // Whole line, word 0 in the low bits
    typedef tWord [`LINE_WORDS-1:0] tLine;

    // Requester id, equal to the port number
    typedef logic [$clog2(`NUM_PORTS)-1:0] tPortId;

    // Fetch buffer sequencer
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT
    } tFetchState;

    // Last granted port for round robin
    typedef enum logic {
        PORT0,
        PORT1
    } tArbOwner;

endpackage

// File: verilog/fetchTop.sv
`include "icache_defines.svh"

module fetchTop (
    input  logic           clk,
    input  logic           reset,
    input  logic           start0,
    input  logic [31:0]    startPc0,
    input  logic [3:0]     lineCount0,
    output logic           busy0,
    output logic           lineValid0,
    output logic [31:0]    linePc0,
    output fetchPkg::tLine lineData0,
    input  logic           start1,
    input  logic [31:0]    startPc1,
    input  logic [3:0]     lineCount1,
    output logic           busy1,
    output logic           lineValid1,
    output logic [31:0]    linePc1,
    output fetchPkg::tLine lineData1
);

    import fetchPkg::*;

    // Fetch buffers to arbiter
    logic        reqValid0;
    logic [31:0] reqAddr0;
    logic        reqValid1;
    logic [31:0] reqAddr1;
    logic        rspValid0;
    logic        rspValid1;
    tLine        rspData;

    // Arbiter to store
    logic        icReqValid;
    logic [31:0] icReqAddr;
    tPortId      icReqId;
    logic        icRspValid;
    tPortId      icRspId;
    tLine        icRspData;

    fetchBuffer i_fetch0 (
        .clk       (clk),
        .reset     (reset),
        .start     (start0),
        .startPc   (startPc0),
        .lineCount (lineCount0),
        .rspValid  (rspValid0),
        .rspData   (rspData),
        .busy      (busy0),
        .lineValid (lineValid0),
        .linePc    (linePc0),
        .lineData  (lineData0),
        .reqValid  (reqValid0),
        .reqAddr   (reqAddr0)
    );

    fetchBuffer i_fetch1 (
        .clk       (clk),
        .reset     (reset),
        .start     (start1),
        .startPc   (startPc1),
        .lineCount (lineCount1),
        .rspValid  (rspValid1),
        .rspData   (rspData),
        .busy      (busy1),
        .lineValid (lineValid1),
        .linePc    (linePc1),
        .lineData  (lineData1),
        .reqValid  (reqValid1),
        .reqAddr   (reqAddr1)
    );

    icacheArbiter i_arbiter (
        .clk        (clk),
        .reset      (reset),
        .reqValid0  (reqValid0),
        .reqAddr0   (reqAddr0),
        .reqValid1  (reqValid1),
        .reqAddr1   (reqAddr1),
        .icRspValid (icRspValid),
        .icRspId    (icRspId),
        .icRspData  (icRspData),
        .rspValid0  (rspValid0),
        .rspValid1  (rspValid1),
        .rspData    (rspData),
        .icReqValid (icReqValid),
        .icReqAddr  (icReqAddr),
        .icReqId    (icReqId)
    );

    icache #(
        .LATENCY (`ICACHE_LATENCY)
    ) i_icache (
        .clk        (clk),
        .reset      (reset),
        .icReqValid (icReqValid),
        .icReqAddr  (icReqAddr),
        .icReqId    (icReqId),
        .icRspValid (icRspValid),
        .icRspId    (icRspId),
        .icRspData  (icRspData)
    );

endmodule

// File: verilog/icache.sv
`include "icache_defines.svh"

module icache #(
    parameter int LATENCY = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             icReqValid,
    input  logic [31:0]      icReqAddr,
    input  fetchPkg::tPortId icReqId,
    output logic             icRspValid,
    output fetchPkg::tPortId icRspId,
    output fetchPkg::tLine   icRspData
);

    import fetchPkg::*;

    localparam int IDX_BITS = $clog2(`ICACHE_WORDS);

    tWord rom [`ICACHE_WORDS];

    logic [IDX_BITS-1:0] wordIdx;
    tLine                readLine;

    // Response pipeline, stage 0 is the lookup
    logic   validPipe [LATENCY];
    tPortId idPipe    [LATENCY];
    tLine   dataPipe  [LATENCY];

    initial begin
        $readmemh("irom.hex", rom);
    end

    assign wordIdx = icReqAddr[IDX_BITS+1:2];

    // Index arithmetic stays IDX_BITS wide, so the line wraps at the end of the store
    always_comb begin
        for (int w = 0; w < `LINE_WORDS; w++) begin
            readLine[w] = rom[wordIdx + IDX_BITS'(w)];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validPipe[0] <= 1'b0;
        end else begin
            validPipe[0] <= icReqValid;
        end
        idPipe[0]   <= icReqId;
        dataPipe[0] <= readLine;
    end

    for (genvar i = 1; i < LATENCY; i++) begin : gStage
        always_ff @(posedge clk) begin
            if (reset) begin
                validPipe[i] <= 1'b0;
            end else begin
                validPipe[i] <= validPipe[i-1];
            end
            idPipe[i]   <= idPipe[i-1];
            dataPipe[i] <= dataPipe[i-1];
        end
    end

    assign icRspValid = validPipe[LATENCY-1];
    assign icRspId    = idPipe[LATENCY-1];
    assign icRspData  = dataPipe[LATENCY-1];

endmodule

// File: verilog/icacheArbiter.sv
module icacheArbiter (
    input  logic             clk,
    input  logic             reset,
    input  logic             reqValid0,
    input  logic [31:0]      reqAddr0,
    input  logic             reqValid1,
    input  logic [31:0]      reqAddr1,
    input  logic             icRspValid,
    input  fetchPkg::tPortId icRspId,
    input  fetchPkg::tLine   icRspData,
    output logic             rspValid0,
    output logic             rspValid1,
    output fetchPkg::tLine   rspData,
    output logic             icReqValid,
    output logic [31:0]      icReqAddr,
    output fetchPkg::tPortId icReqId
);

    import fetchPkg::*;

    // One pending slot per port
    logic        pending0;
    logic        pending1;
    logic [31:0] slotAddr0;
    logic [31:0] slotAddr1;

    tArbOwner owner;
    logic     grant0;
    logic     grant1;

    // Port 0 wins a tie unless it was granted last
    assign grant0 = pending0 & (~pending1 | (owner == PORT1));
    assign grant1 = pending1 & ~grant0;

    assign icReqValid = grant0 | grant1;
    assign icReqAddr  = grant1 ? slotAddr1 : slotAddr0;
    assign icReqId    = grant1 ? tPortId'(1) : tPortId'(0);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending0 <= 1'b0;
            pending1 <= 1'b0;
            owner    <= PORT1;
        end else begin
            // Clear on grant first, a new strobe then refills the slot
            if (grant0) begin
                pending0 <= 1'b0;
                owner    <= PORT0;
            end
            if (grant1) begin
                pending1 <= 1'b0;
                owner    <= PORT1;
            end
            if (reqValid0) begin
                pending0 <= 1'b1;
            end
            if (reqValid1) begin
                pending1 <= 1'b1;
            end
        end
    end

    // Slot addresses only matter while the flag is set
    always_ff @(posedge clk) begin
        if (reqValid0) begin
            slotAddr0 <= reqAddr0;
        end
        if (reqValid1) begin
            slotAddr1 <= reqAddr1;
        end
    end

    // Route responses back by id
    assign rspValid0 = icRspValid & (icRspId == tPortId'(0));
    assign rspValid1 = icRspValid & (icRspId == tPortId'(1));
    assign rspData   = icRspData;

endmodule

// File: verilog/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Instruction store depth in 32-bit words
`define ICACHE_WORDS 128

// Words returned per request
`define LINE_WORDS 4

// Cycles from request strobe to response strobe
`define ICACHE_LATENCY 2

// Fetch ports sharing the store
`define NUM_PORTS 2

`endif
